// ==== Makefile ====
TOP ?= tb_leaf_wrapper
FILELIST ?= leaf_wrapper.f
LOG ?= sim.log
VERILATOR ?= verilator
OBJ_DIR ?= obj_dir
PASS_TEXT := Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== leaf_wrapper.f ====
verilog/bft_pkg.sv
verilog/leaf_pkg.sv
verilog/stream_fifo.sv
verilog/packet_receiver.sv
verilog/packet_sender.sv
verilog/leaf_interface.sv
verilog/user_kernel.sv
verilog/leaf_wrapper.sv
testbench/tb_leaf_wrapper.sv

// ==== testbench/leaf_cases.txt ====
# c out_port dest_leaf dest_port enable | d valid leaf port payload | r cycles
# e dest_leaf dest_port sequence payload | s section. Numbers decimal, payloads hex.
# Section 1: no output enabled yet, sums of ports 1, 3 and 5 are held.
d 1 1 1 00000001
d 1 1 2 00000002
d 1 1 3 00000003
d 1 1 4 00000004
d 1 1 5 00000005
d 1 1 6 00000006
s 1
# Section 2: enabling the table releases the held sums.
c 1 2 1 1
c 2 5 2 1
c 3 3 3 1
c 4 6 4 1
c 5 4 5 1
c 6 7 6 1
e 2 1 0 00000003
e 3 3 0 00000007
e 4 5 0 0000000b
s 2
# Section 3: word pairs, wrapping sums and sequence numbers.
d 1 1 2 0000000a
d 1 1 3 00000014
d 1 1 4 ffffffff
d 1 1 5 00000002
d 1 1 1 00000005
d 1 1 2 00000006
d 1 1 1 00000007
d 1 1 2 00000008
e 5 2 0 0000001e
e 6 4 0 00000001
e 2 1 1 0000000b
e 2 1 2 0000000f
s 3
# Section 4: foreign leaf, clear valid, bad port, and an overfull input queue.
d 1 3 1 dead0001
d 0 1 1 dead0002
d 1 1 9 dead0003
d 1 1 2 00000003
d 1 1 3 00000004
d 1 1 7 00000001
d 1 1 7 00000002
d 1 1 7 00000003
d 1 1 7 00000004
d 1 1 7 00000005
d 1 1 6 00000010
d 1 1 6 00000020
d 1 1 6 00000030
d 1 1 6 00000040
d 1 1 7 00000006
d 1 1 6 00000050
e 5 2 1 00000007
e 7 6 0 00000011
e 7 6 1 00000022
e 7 6 2 00000033
e 7 6 3 00000044
e 7 6 4 00000056
s 4
# Section 5: resend while packets are in flight.
d 1 1 1 00000100
d 1 1 2 00000023
d 1 1 3 00000007
d 1 1 4 00000008
d 1 1 5 12345678
d 1 1 6 11111111
r 12
e 2 1 3 00000123
e 3 3 1 0000000f
e 4 5 1 23456789
s 5
# Section 6: output 2 moves to a new destination.
c 2 9 7 1
d 1 1 2 00000040
d 1 1 3 00000002
e 9 7 2 00000042
s 6

// ==== testbench/tb_leaf_wrapper.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_leaf_wrapper;

    localparam int THIS_LEAF = 1;
    localparam int PB = bft_pkg::PACKET_BITS;
    localparam int SETTLE_CYCLES = 24;

    logic clk;
    logic rst_n;
    logic [PB-1:0] din;
    logic [PB-1:0] dout;
    logic resend;

    // Case lines, one entry per line of the file.
    logic [7:0] kinds[$];
    int unsigned arg_a[$];
    int unsigned arg_b[$];
    int unsigned arg_c[$];
    int unsigned arg_d[$];

    // Packets keyed by destination port.
    logic [PB-1:0] got_q [16][$];
    logic [PB-1:0] exp_q [16][$];
    int got_total = 0;
    int exp_total = 0;
    int err_count = 0;
    int check_count = 0;
    int section_count = 0;
    int section_err_base = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    bft_pkg::packet_t seen;

    leaf_wrapper #(
        .LEAF_ID(THIS_LEAF)
    ) dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .din_leaf_bft2interface(din),
        .dout_leaf_interface2bft(dout),
        .resend(resend)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================
    // Helpers.
    // ========================================
    function automatic logic [PB-1:0] build_packet(input logic valid, input logic [4:0] leaf,
            input logic [3:0] port, input logic [6:0] addr, input logic [31:0] payload);
        return {valid, leaf, port, addr, payload};
    endfunction

    // Target port, destination leaf, destination port and enable, low bits upward.
    function automatic logic [31:0] config_word(input int unsigned out_port,
            input int unsigned leaf, input int unsigned dport, input int unsigned en);
        return 32'(out_port & 15) | (32'(leaf & 31) << 4) | (32'(dport & 15) << 9)
             | (32'(en & 1) << 13);
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
            input string what);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("error at %0.2f ns: %s, got %h, expected %h", $realtime, what, actual,
                     expected);
        end
    endtask

    task automatic send_packet(input logic [PB-1:0] pkt);
        @(negedge clk);
        din = pkt;
        @(negedge clk);
        din = '0;
    endtask

    task automatic hold_resend(input int unsigned cycles);
        @(negedge clk);
        resend = 1'b1;
        repeat (cycles) @(negedge clk);
        resend = 1'b0;
    endtask

    task automatic expect_packet(input int unsigned leaf, input int unsigned port,
            input int unsigned seq, input int unsigned payload);
        exp_q[port % 16].push_back(build_packet(1'b1, 5'(leaf), 4'(port), 7'(seq), payload));
        exp_total++;
    endtask

    task automatic finish_section(input int unsigned num);
        int packets;
        logic [PB-1:0] got_pkt;
        logic [PB-1:0] exp_pkt;
        packets = exp_total;
        while (got_total < exp_total) begin
            @(negedge clk);
        end
        // Late or duplicated packets would show up here.
        repeat (SETTLE_CYCLES) @(negedge clk);
        for (int p = 0; p < 16; p++) begin
            check_value(64'(got_q[p].size()), 64'(exp_q[p].size()),
                        $sformatf("packet count for port %0d", p));
            while (got_q[p].size() > 0 && exp_q[p].size() > 0) begin
                got_pkt = got_q[p].pop_front();
                exp_pkt = exp_q[p].pop_front();
                check_value(64'(got_pkt), 64'(exp_pkt), $sformatf("packet for port %0d", p));
            end
            got_q[p].delete();
            exp_q[p].delete();
        end
        got_total = 0;
        exp_total = 0;
        section_count++;
        if (err_count == section_err_base) begin
            $display("section %0d: ok, %0d packets", num, packets);
        end else begin
            $display("section %0d: %0d errors", num, err_count - section_err_base);
        end
        section_err_base = err_count;
    endtask

    task automatic read_cases();
        int fd;
        int n;
        logic [7:0] kind;
        int unsigned a;
        int unsigned b;
        int unsigned c;
        int unsigned d;
        logic [8*120-1:0] rest;
        bit stop;
        fd = $fopen("testbench/leaf_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file testbench/leaf_cases.txt");
            err_count++;
        end else begin
            stop = 1'b0;
            while (!stop && !$feof(fd)) begin
                n = $fscanf(fd, "%s", kind);
                if (n == 1 && kind == "#") begin
                    n = $fgets(rest, fd);
                end else if (n == 1) begin
                    a = 0;
                    b = 0;
                    c = 0;
                    d = 0;
                    if (kind == "c" || kind == "d" || kind == "e") begin
                        n = $fscanf(fd, "%d %d %d %h", a, b, c, d) - 4;
                    end else if (kind == "r" || kind == "s") begin
                        n = $fscanf(fd, "%d", a) - 1;
                    end else begin
                        n = -1;
                    end
                    if (n == 0) begin
                        kinds.push_back(kind);
                        arg_a.push_back(a);
                        arg_b.push_back(b);
                        arg_c.push_back(c);
                        arg_d.push_back(d);
                    end else begin
                        $display("case file entry %0d could not be read", kinds.size() + 1);
                        err_count++;
                        stop = 1'b1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_cases();
        logic [31:0] cfg;
        for (int i = 0; i < kinds.size(); i++) begin
            if (kinds[i] == "c") begin
                cfg = config_word(arg_a[i], arg_b[i], arg_c[i], arg_d[i]);
                send_packet(build_packet(1'b1, 5'(THIS_LEAF), 4'(leaf_pkg::CFG_PORT), 7'd0, cfg));
            end else if (kinds[i] == "d") begin
                send_packet(build_packet(1'(arg_a[i]), 5'(arg_b[i]), 4'(arg_c[i]), 7'd0,
                                         arg_d[i]));
            end else if (kinds[i] == "r") begin
                hold_resend(arg_a[i]);
            end else if (kinds[i] == "e") begin
                expect_packet(arg_a[i], arg_b[i], arg_c[i], arg_d[i]);
            end else begin
                finish_section(arg_a[i]);
            end
        end
    endtask

    // ========================================
    // Output monitor.
    // ========================================
    always @(posedge clk) begin
        if (rst_n) begin
            if (resend) begin
                check_value(64'(dout), 64'd0, "output during resend");
            end else if (dout[PB-1]) begin
                seen = dout;
                got_q[seen.port].push_back(dout);
                got_total++;
            end
        end
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the cases did not finish within %0d clock cycles", cycle_limit);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        din = '0;
        resend = 1'b0;
        read_cases();
        cycle_limit = 200 + 20 * kinds.size();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_value(64'(dout), 64'd0, "output after reset");
        check_value(64'(dut0.vld_interface2user), 64'h0, "input word valids after reset");
        check_value(64'(dut0.ack_interface2user), 64'h3f, "output word acks after reset");
        if (err_count == 0) begin
            run_cases();
        end
        $display("%0d sections, %0d checks, %0d errors", section_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/bft_pkg.sv ====
`default_nettype none

package bft_pkg;

    // ========================================
    // Tree packet fields.
    // ========================================
    localparam int PACKET_BITS = 49;
    localparam int LEAF_BITS = 5;
    localparam int PORT_BITS = 4;
    localparam int ADDR_BITS = 7;
    localparam int PAYLOAD_BITS = 32;

    // Packed from the top: valid, leaf, port, address, payload.
    // The address field carries the per-port sequence number.
    typedef struct packed {
        logic                    valid;
        logic [LEAF_BITS-1:0]    leaf;
        logic [PORT_BITS-1:0]    port;
        logic [ADDR_BITS-1:0]    addr;
        logic [PAYLOAD_BITS-1:0] payload;
    } packet_t;

endpackage

`default_nettype wire

// ==== verilog/leaf_interface.sv ====
`timescale 1ns/10ps
`default_nettype none

module leaf_interface #(
    parameter int LEAF_ID = 1,
    parameter int NUM_IN_PORTS = 7,
    parameter int NUM_OUT_PORTS = 6,
    parameter int FIFO_DEPTH = 4,
    parameter int OUT_DEPTH = 8
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire [bft_pkg::PACKET_BITS-1:0]              din_leaf_bft2interface,
    output wire [bft_pkg::PACKET_BITS-1:0]              dout_leaf_interface2bft,
    input  wire                                         resend,
    output wire [NUM_IN_PORTS*leaf_pkg::WORD_BITS-1:0]  dout_leaf_interface2user,
    output wire [NUM_IN_PORTS-1:0]                      vld_interface2user,
    input  wire [NUM_IN_PORTS-1:0]                      ack_user2interface,
    input  wire [NUM_OUT_PORTS*leaf_pkg::WORD_BITS-1:0] din_leaf_user2interface,
    input  wire [NUM_OUT_PORTS-1:0]                     vld_user2interface,
    output wire [NUM_OUT_PORTS-1:0]                     ack_interface2user
);

    localparam int W = leaf_pkg::WORD_BITS;

    wire [NUM_IN_PORTS-1:0] in_push;
    wire [NUM_IN_PORTS-1:0] in_empty;
    wire [NUM_IN_PORTS-1:0] in_full;
    leaf_pkg::word_t in_data;
    wire cfg_we;
    leaf_pkg::word_t cfg_data;

    wire [NUM_OUT_PORTS-1:0] out_pop;
    wire [NUM_OUT_PORTS-1:0] out_empty;
    wire [NUM_OUT_PORTS-1:0] out_full;
    wire [NUM_OUT_PORTS*W-1:0] out_data;

    packet_receiver #(
        .LEAF_ID(LEAF_ID),
        .NUM_IN_PORTS(NUM_IN_PORTS)
    ) rx (
        .clk(clk),
        .rst_n(rst_n),
        .din_leaf_bft2interface(din_leaf_bft2interface),
        .in_full(in_full),
        .push(in_push),
        .push_data(in_data),
        .cfg_we(cfg_we),
        .cfg_data(cfg_data)
    );

    // Words toward the kernel, port 1 in slice 0.
    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_in_q
        stream_fifo #(.payload_t(leaf_pkg::word_t), .DEPTH(FIFO_DEPTH)) in_q (
            .clk(clk),
            .rst_n(rst_n),
            .push(in_push[i]),
            .push_data(in_data),
            .pop(ack_user2interface[i]),
            .pop_data(dout_leaf_interface2user[i*W +: W]),
            .empty(in_empty[i]),
            .full(in_full[i])
        );
    end

    assign vld_interface2user = ~in_empty;

    // Words from the kernel, waiting for the sender.
    for (genvar j = 0; j < NUM_OUT_PORTS; j++) begin : g_out_q
        stream_fifo #(.payload_t(leaf_pkg::word_t), .DEPTH(FIFO_DEPTH)) out_q (
            .clk(clk),
            .rst_n(rst_n),
            .push(vld_user2interface[j] && ack_interface2user[j]),
            .push_data(din_leaf_user2interface[j*W +: W]),
            .pop(out_pop[j]),
            .pop_data(out_data[j*W +: W]),
            .empty(out_empty[j]),
            .full(out_full[j])
        );
    end

    assign ack_interface2user = ~out_full;

    packet_sender #(
        .NUM_OUT_PORTS(NUM_OUT_PORTS),
        .OUT_DEPTH(OUT_DEPTH)
    ) tx (
        .clk(clk),
        .rst_n(rst_n),
        .cfg_we(cfg_we),
        .cfg_data(cfg_data),
        .out_empty(out_empty),
        .out_data(out_data),
        .out_pop(out_pop),
        .resend(resend),
        .dout(dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

// ==== verilog/leaf_pkg.sv ====
`default_nettype none

package leaf_pkg;

    localparam int WORD_BITS = bft_pkg::PAYLOAD_BITS;

    typedef logic [WORD_BITS-1:0] word_t;

    // Packets addressed to this port write the destination table.
    localparam int CFG_PORT = 0;

    // ========================================
    // Configuration payload, low bits upward.
    // ========================================
    localparam int CFG_TARGET_LSB = 0;
    localparam int CFG_LEAF_LSB = CFG_TARGET_LSB + bft_pkg::PORT_BITS;
    localparam int CFG_DPORT_LSB = CFG_LEAF_LSB + bft_pkg::LEAF_BITS;
    localparam int CFG_EN_POS = CFG_DPORT_LSB + bft_pkg::PORT_BITS;

endpackage

`default_nettype wire

// ==== verilog/leaf_wrapper.sv ====
`timescale 1ns/10ps
`default_nettype none

module leaf_wrapper #(
    parameter int LEAF_ID = 1,
    parameter int NUM_IN_PORTS = 7,
    parameter int NUM_OUT_PORTS = 6,
    parameter int FIFO_DEPTH = 4,
    parameter int OUT_DEPTH = 8
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire [bft_pkg::PACKET_BITS-1:0] din_leaf_bft2interface,
    output wire [bft_pkg::PACKET_BITS-1:0] dout_leaf_interface2bft,
    input  wire                            resend
);

    localparam int W = leaf_pkg::WORD_BITS;

    wire [NUM_IN_PORTS*W-1:0] dout_leaf_interface2user;
    wire [NUM_IN_PORTS-1:0] vld_interface2user;
    wire [NUM_IN_PORTS-1:0] ack_user2interface;
    wire [NUM_OUT_PORTS*W-1:0] din_leaf_user2interface;
    wire [NUM_OUT_PORTS-1:0] vld_user2interface;
    wire [NUM_OUT_PORTS-1:0] ack_interface2user;
    wire [bft_pkg::PACKET_BITS-1:0] dout_tmp;

    // Nothing leaves the leaf while the tree asks for a resend.
    assign dout_leaf_interface2bft = resend ? '0 : dout_tmp;

    leaf_interface #(
        .LEAF_ID(LEAF_ID),
        .NUM_IN_PORTS(NUM_IN_PORTS),
        .NUM_OUT_PORTS(NUM_OUT_PORTS),
        .FIFO_DEPTH(FIFO_DEPTH),
        .OUT_DEPTH(OUT_DEPTH)
    ) leaf_interface_inst (
        .clk(clk),
        .rst_n(rst_n),
        .din_leaf_bft2interface(din_leaf_bft2interface),
        .dout_leaf_interface2bft(dout_tmp),
        .resend(resend),
        .dout_leaf_interface2user(dout_leaf_interface2user),
        .vld_interface2user(vld_interface2user),
        .ack_user2interface(ack_user2interface),
        .din_leaf_user2interface(din_leaf_user2interface),
        .vld_user2interface(vld_user2interface),
        .ack_interface2user(ack_interface2user)
    );

    user_kernel #(
        .NUM_IN_PORTS(NUM_IN_PORTS),
        .NUM_OUT_PORTS(NUM_OUT_PORTS)
    ) user_kernel_inst (
        .clk(clk),
        .rst_n(rst_n),
        .dout_leaf_interface2user(dout_leaf_interface2user),
        .vld_interface2user(vld_interface2user),
        .ack_user2interface(ack_user2interface),
        .din_leaf_user2interface(din_leaf_user2interface),
        .vld_user2interface(vld_user2interface),
        .ack_interface2user(ack_interface2user)
    );

endmodule

`default_nettype wire

// ==== verilog/packet_receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

module packet_receiver #(
    parameter int LEAF_ID = 1,
    parameter int NUM_IN_PORTS = 7
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire [bft_pkg::PACKET_BITS-1:0]     din_leaf_bft2interface,
    input  wire [NUM_IN_PORTS-1:0]             in_full,
    output logic [NUM_IN_PORTS-1:0]            push,
    output leaf_pkg::word_t                    push_data,
    output logic                               cfg_we,
    output leaf_pkg::word_t                    cfg_data
);

    localparam logic [bft_pkg::LEAF_BITS-1:0] MY_LEAF = (bft_pkg::LEAF_BITS)'(LEAF_ID);

    bft_pkg::packet_t pkt;
    logic for_me;
    logic [NUM_IN_PORTS-1:0] sel_q;
    leaf_pkg::word_t payload_q;

    assign pkt = din_leaf_bft2interface;
    assign for_me = pkt.valid && (pkt.leaf == MY_LEAF);

    // Decode on arrival.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q <= '0;
            cfg_we <= 1'b0;
        end else begin
            cfg_we <= for_me && (pkt.port == (bft_pkg::PORT_BITS)'(leaf_pkg::CFG_PORT));
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                sel_q[i] <= for_me && (pkt.port == (bft_pkg::PORT_BITS)'(i + 1));
            end
        end
    end

    always_ff @(posedge clk) begin
        payload_q <= pkt.payload;
    end

    // The full check is made at push time, so a push still in flight
    // is already counted by the queue.
    assign push = sel_q & ~in_full;
    assign push_data = payload_q;
    assign cfg_data = payload_q;

    a_push_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(push))
        else $error("packet_receiver: more than one queue pushed");

endmodule

`default_nettype wire

// ==== verilog/packet_sender.sv ====
`timescale 1ns/10ps
`default_nettype none

module packet_sender #(
    parameter int NUM_OUT_PORTS = 6,
    parameter int OUT_DEPTH = 8
) (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire                                        cfg_we,
    input  wire leaf_pkg::word_t                       cfg_data,
    input  wire [NUM_OUT_PORTS-1:0]                    out_empty,
    input  wire [NUM_OUT_PORTS*leaf_pkg::WORD_BITS-1:0] out_data,
    output logic [NUM_OUT_PORTS-1:0]                   out_pop,
    input  wire                                        resend,
    output logic [bft_pkg::PACKET_BITS-1:0]            dout
);

    localparam int W = leaf_pkg::WORD_BITS;
    localparam int SEL_BITS = (NUM_OUT_PORTS > 1) ? $clog2(NUM_OUT_PORTS) : 1;

    logic [NUM_OUT_PORTS-1:0] tbl_en;
    logic [bft_pkg::LEAF_BITS-1:0] tbl_leaf [NUM_OUT_PORTS];
    logic [bft_pkg::PORT_BITS-1:0] tbl_port [NUM_OUT_PORTS];
    logic [bft_pkg::ADDR_BITS-1:0] seq [NUM_OUT_PORTS];
    logic [bft_pkg::PORT_BITS-1:0] cfg_target;

    logic [SEL_BITS-1:0] rr_ptr;
    logic [SEL_BITS-1:0] sel;
    logic found;
    logic route;
    bft_pkg::packet_t pkt;
    bft_pkg::packet_t q_head;
    logic q_empty;
    logic q_full;
    logic q_pop;

    // ========================================
    // Destination table.
    // ========================================
    // Target output ports count from 1, as on the user side.
    assign cfg_target = cfg_data[leaf_pkg::CFG_TARGET_LSB +: bft_pkg::PORT_BITS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tbl_en <= '0;
        end else if (cfg_we) begin
            for (int j = 0; j < NUM_OUT_PORTS; j++) begin
                if (cfg_target == (bft_pkg::PORT_BITS)'(j + 1)) begin
                    tbl_en[j] <= cfg_data[leaf_pkg::CFG_EN_POS];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            if (cfg_we && cfg_target == (bft_pkg::PORT_BITS)'(j + 1)) begin
                tbl_leaf[j] <= cfg_data[leaf_pkg::CFG_LEAF_LSB +: bft_pkg::LEAF_BITS];
                tbl_port[j] <= cfg_data[leaf_pkg::CFG_DPORT_LSB +: bft_pkg::PORT_BITS];
            end
        end
    end

    // ========================================
    // Round robin and packet assembly.
    // ========================================
    always_comb begin
        int idx;
        found = 1'b0;
        sel = rr_ptr;
        for (int k = 1; k <= NUM_OUT_PORTS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_OUT_PORTS;
            if (!found && !out_empty[idx] && tbl_en[idx]) begin
                found = 1'b1;
                sel = SEL_BITS'(idx);
            end
        end
    end

    assign route = found && !q_full;
    assign out_pop = route ? (NUM_OUT_PORTS'(1) << sel) : '0;

    assign pkt.valid = 1'b1;
    assign pkt.leaf = tbl_leaf[sel];
    assign pkt.port = tbl_port[sel];
    assign pkt.addr = seq[sel];
    assign pkt.payload = out_data[sel*W +: W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= SEL_BITS'(NUM_OUT_PORTS - 1);
            for (int j = 0; j < NUM_OUT_PORTS; j++) begin
                seq[j] <= '0;
            end
        end else if (route) begin
            rr_ptr <= sel;
            seq[sel] <= seq[sel] + 1'b1;
        end
    end

    // ========================================
    // Outbound queue.
    // ========================================
    stream_fifo #(
        .payload_t(bft_pkg::packet_t),
        .DEPTH(OUT_DEPTH)
    ) out_q (
        .clk(clk),
        .rst_n(rst_n),
        .push(route),
        .push_data(pkt),
        .pop(q_pop),
        .pop_data(q_head),
        .empty(q_empty),
        .full(q_full)
    );

    assign q_pop = !q_empty && !resend;

    // A packet on dout is held through resend and goes out again after.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout <= '0;
        end else if (!resend) begin
            dout <= q_pop ? q_head : '0;
        end
    end

    a_pop_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(out_pop))
        else $error("packet_sender: more than one output queue popped");

endmodule

`default_nettype wire

// ==== verilog/stream_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int DEPTH = 4
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           push,
    input  wire payload_t push_data,
    input  wire           pop,
    output payload_t      pop_data,
    output logic          empty,
    output logic          full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0] count;
    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop = pop && !empty;
    assign empty = (count == '0);
    assign full = (count == CNT_BITS'(DEPTH));
    // Head is shown as soon as it is written.
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // The producer and consumer sit in other modules.
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("stream_fifo: pop while empty");
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("stream_fifo: push while full");

endmodule

`default_nettype wire

// ==== verilog/user_kernel.sv ====
`timescale 1ns/10ps
`default_nettype none

module user_kernel #(
    parameter int NUM_IN_PORTS = 7,
    parameter int NUM_OUT_PORTS = 6
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire [NUM_IN_PORTS*leaf_pkg::WORD_BITS-1:0]  dout_leaf_interface2user,
    input  wire [NUM_IN_PORTS-1:0]                      vld_interface2user,
    output wire [NUM_IN_PORTS-1:0]                      ack_user2interface,
    output logic [NUM_OUT_PORTS*leaf_pkg::WORD_BITS-1:0] din_leaf_user2interface,
    output logic [NUM_OUT_PORTS-1:0]                    vld_user2interface,
    input  wire [NUM_OUT_PORTS-1:0]                     ack_interface2user
);

    localparam int W = leaf_pkg::WORD_BITS;

    if (NUM_IN_PORTS != NUM_OUT_PORTS + 1) begin : g_port_check
        $error("user_kernel needs one more input port than output ports");
    end

    logic [NUM_OUT_PORTS-1:0] want;
    logic [NUM_OUT_PORTS-1:0] take;
    wire [NUM_OUT_PORTS+1:0] take_pad;

    // Output j adds inputs j and j+1 once its register can accept a word.
    assign want = vld_interface2user[NUM_OUT_PORTS-1:0] & vld_interface2user[NUM_OUT_PORTS:1]
                & (~vld_user2interface | ack_interface2user);

    // Neighbours share an input; the lower output goes first.
    always_comb begin
        logic prev;
        prev = 1'b0;
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            take[j] = want[j] && !prev;
            prev = take[j];
        end
    end

    assign take_pad = {1'b0, take, 1'b0};
    assign ack_user2interface = take_pad[NUM_IN_PORTS-1:0] | take_pad[NUM_IN_PORTS:1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_user2interface <= '0;
        end else begin
            for (int j = 0; j < NUM_OUT_PORTS; j++) begin
                if (take[j]) begin
                    vld_user2interface[j] <= 1'b1;
                end else if (ack_interface2user[j]) begin
                    vld_user2interface[j] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            if (take[j]) begin
                din_leaf_user2interface[j*W +: W] <= dout_leaf_interface2user[j*W +: W]
                                                   + dout_leaf_interface2user[(j+1)*W +: W];
            end
        end
    end

endmodule

`default_nettype wire
